// File: logic/mm_pkg.sv
package mm_pkg;

  // --------------------------------------------------
  // element and word widths
  // --------------------------------------------------
  localparam int DATA_W = 32;  // one element, lane sum or row result

  typedef logic [DATA_W-1:0] word_t;

  // --------------------------------------------------
  // engine constants
  // --------------------------------------------------
  // unsigned multiply core depth, sign fix-up register comes on top
  localparam int MULT_DEPTH = 6;

  localparam int ADDR_W = 8;  // output word address
  localparam int SIZE_W = 32;  // row length in elements

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [SIZE_W-1:0] size_t;

endpackage

// File: logic/mm_simd_multiplier.sv
module mm_simd_multiplier #(
  parameter int SIMD_WIDTH = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              vec_valid,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    a_lanes,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    b_lanes,
  output logic                              prod_valid,
  output mm_pkg::word_t [SIMD_WIDTH-1:0]    prod_lanes
);

  localparam int DW    = mm_pkg::DATA_W;
  localparam int DEPTH = mm_pkg::MULT_DEPTH;

  // two's complement magnitude, most negative value stays 2^(DW-1) unsigned
  function automatic mm_pkg::word_t abs_word(input mm_pkg::word_t w);
    abs_word = w[DW-1] ? (~w + 1'b1) : w;
  endfunction

  // --------------------------------------------------
  // valid pipeline, shared by all lanes
  // --------------------------------------------------
  logic [DEPTH-1:0] vld_pipe;

  always_ff @(posedge CLK) begin
    if (RST) begin
      vld_pipe   <= '0;
      prod_valid <= 1'b0;
    end else begin
      vld_pipe   <= {vld_pipe[DEPTH-2:0], vec_valid};
      prod_valid <= vld_pipe[DEPTH-1];  // lines up with the sign fix-up reg
    end
  end

  // --------------------------------------------------
  // per lane sign-magnitude multiply
  // --------------------------------------------------
  for (genvar i = 0; i < SIMD_WIDTH; i++) begin : g_lane
    mm_pkg::word_t       op_a;  // core input regs, stage 1
    mm_pkg::word_t       op_b;
    logic [2*DW-1:0]     mag_pipe [DEPTH-1];  // stages 2..DEPTH
    logic [2*DW-1:0]     mag;
    logic [2*DW-1:0]     signed_full;
    logic [DEPTH-1:0]    sa_pipe;  // operand signs ride along
    logic [DEPTH-1:0]    sb_pipe;

    always_ff @(posedge CLK) begin
      op_a        <= abs_word(a_lanes[i]);
      op_b        <= abs_word(b_lanes[i]);
      mag_pipe[0] <= op_a * op_b;  // full width unsigned product
      for (int k = 1; k < DEPTH - 1; k++) begin
        mag_pipe[k] <= mag_pipe[k-1];
      end
      sa_pipe <= {sa_pipe[DEPTH-2:0], a_lanes[i][DW-1]};
      sb_pipe <= {sb_pipe[DEPTH-2:0], b_lanes[i][DW-1]};
    end

    assign mag = mag_pipe[DEPTH-2];

    // negate when signs differ
    assign signed_full = (sa_pipe[DEPTH-1] ^ sb_pipe[DEPTH-1]) ? (~mag + 1'b1) : mag;

    always_ff @(posedge CLK) begin
      prod_lanes[i] <= signed_full[DW-1:0];  // low word, product mod 2^32
    end
  end

  // downstream counters step on this strobe, an X here corrupts the row count
  a_prod_valid_known : assert property (
    @(posedge CLK) disable iff (RST) !$isunknown(prod_valid)
  );

endmodule

// File: logic/mm_row_accumulator.sv
module mm_row_accumulator #(
  parameter int SIMD_WIDTH = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  mm_pkg::size_t                     matrix_size,
  input  logic                              prod_valid,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    prod_lanes,
  output mm_pkg::word_t [SIMD_WIDTH-1:0]    row_sums,
  output logic                              row_done
);

  localparam mm_pkg::size_t STEP = mm_pkg::size_t'(SIMD_WIDTH);  // elements per word

  mm_pkg::size_t                     row_len;   // latched on start
  mm_pkg::size_t                     elem_cnt;  // elements seen in current row
  mm_pkg::word_t [SIMD_WIDTH-1:0]    run_sums;
  logic                              row_end;

  assign row_end = (elem_cnt + STEP >= row_len);  // this word closes the row

  // --------------------------------------------------
  // row counting
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      row_len  <= '0;
      elem_cnt <= '0;
      row_done <= 1'b0;
    end else begin
      row_done <= 1'b0;
      if (start) begin
        row_len  <= matrix_size;
        elem_cnt <= '0;
      end else if (prod_valid) begin
        if (row_end) begin
          elem_cnt <= '0;
          row_done <= 1'b1;
        end else begin
          elem_cnt <= elem_cnt + STEP;
        end
      end
    end
  end

  // running lane sums, wrap mod 2^32
  always_ff @(posedge CLK) begin
    if (RST || start) begin
      run_sums <= '0;  // no leftovers from a previous matrix
    end else if (prod_valid) begin
      for (int i = 0; i < SIMD_WIDTH; i++) begin
        run_sums[i] <= row_end ? '0 : run_sums[i] + prod_lanes[i];
      end
    end
  end

  // capture of the finished row, held until the next row end
  always_ff @(posedge CLK) begin
    if (prod_valid && row_end && !start) begin
      for (int i = 0; i < SIMD_WIDTH; i++) begin
        row_sums[i] <= run_sums[i] + prod_lanes[i];
      end
    end
  end

  a_size_legal : assert property (
    @(posedge CLK) disable iff (RST)
    start |-> (matrix_size != 0) && ((matrix_size % SIMD_WIDTH) == 0)
  );

  // source must drain the multiplier before restarting
  a_no_prod_on_start : assert property (
    @(posedge CLK) disable iff (RST) !(prod_valid && start)
  );

endmodule

// File: logic/mm_adder_tree.sv
module mm_adder_tree #(
  parameter int SIMD_WIDTH = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    row_sums,
  input  logic                              row_done,
  output mm_pkg::word_t                     row_result,
  output logic                              result_valid
);

  localparam int LOG_W = $clog2(SIMD_WIDTH);  // tree levels

  // --------------------------------------------------
  // pairwise reduction, one register level per step
  // --------------------------------------------------
  for (genvar l = 0; l < LOG_W; l++) begin : g_lvl
    localparam int N = SIMD_WIDTH >> (l + 1);  // nodes at this level
    mm_pkg::word_t [N-1:0] sum;
    logic                  vld;

    if (l == 0) begin : g_first
      always_ff @(posedge CLK) begin
        for (int j = 0; j < N; j++) begin
          sum[j] <= row_sums[2*j] + row_sums[2*j+1];  // leaves from captured sums
        end
      end
      always_ff @(posedge CLK) begin
        vld <= RST ? 1'b0 : row_done;
      end
    end else begin : g_next
      always_ff @(posedge CLK) begin
        for (int j = 0; j < N; j++) begin
          sum[j] <= g_lvl[l-1].sum[2*j] + g_lvl[l-1].sum[2*j+1];
        end
      end
      always_ff @(posedge CLK) begin
        vld <= RST ? 1'b0 : g_lvl[l-1].vld;
      end
    end
  end

  if (LOG_W == 0) begin : g_single
    mm_pkg::word_t buf_sum;  // single lane, one buffer stage keeps 1 cycle
    logic          buf_vld;
    always_ff @(posedge CLK) begin
      buf_sum <= row_sums[0];
      buf_vld <= RST ? 1'b0 : row_done;
    end
    assign row_result   = buf_sum;
    assign result_valid = buf_vld;
  end else begin : g_root
    assign row_result   = g_lvl[LOG_W-1].sum[0];
    assign result_valid = g_lvl[LOG_W-1].vld;
  end

endmodule

// File: logic/mm_result_packer.sv
module mm_result_packer #(
  parameter int SIMD_WIDTH = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  mm_pkg::word_t                     row_result,
  input  logic                              result_valid,
  output mm_pkg::word_t [SIMD_WIDTH-1:0]    c_data,
  output mm_pkg::addr_t                     c_addr,
  output logic                              c_we
);

  localparam int LOG_W = $clog2(SIMD_WIDTH);
  localparam int CNT_W = (LOG_W > 0) ? LOG_W : 1;  // single lane still needs a bit
  localparam logic [CNT_W-1:0] LAST_LANE = CNT_W'(SIMD_WIDTH - 1);

  logic [CNT_W-1:0] lane_cnt;   // results packed into current word
  mm_pkg::addr_t    next_addr;  // address for the next full word
  logic             word_full;

  assign word_full = (lane_cnt == LAST_LANE);

  // --------------------------------------------------
  // lane counting and write strobe
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST || start) begin
      lane_cnt  <= '0;
      next_addr <= '0;
      c_addr    <= '0;
      c_we      <= 1'b0;
    end else begin
      c_we <= 1'b0;  // single cycle pulse
      if (result_valid) begin
        if (word_full) begin
          lane_cnt  <= '0;
          c_we      <= 1'b1;
          c_addr    <= next_addr;
          next_addr <= next_addr + 1'b1;  // counts on, no wrap
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
    end
  end

  // newest row enters the top lane, older rows move down toward lane 0
  always_ff @(posedge CLK) begin
    if (result_valid) begin
      for (int i = 0; i < SIMD_WIDTH - 1; i++) begin
        c_data[i] <= c_data[i+1];
      end
      c_data[SIMD_WIDTH-1] <= row_result;
    end
  end

  // tree spacing vs lane count, only one lane can fill on every result
  a_we_single : assert property (
    @(posedge CLK) disable iff (RST) (c_we && SIMD_WIDTH > 1) |=> !c_we
  );

endmodule

// File: logic/mm_dot_engine.sv
module mm_dot_engine #(
  parameter int SIMD_WIDTH = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  mm_pkg::size_t                     matrix_size,
  input  logic                              vec_valid,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    a_lanes,
  input  mm_pkg::word_t [SIMD_WIDTH-1:0]    b_lanes,
  output mm_pkg::word_t [SIMD_WIDTH-1:0]    c_data,
  output mm_pkg::addr_t                     c_addr,
  output logic                              c_we
);

  // --------------------------------------------------
  // inter-stage signals
  // --------------------------------------------------
  logic                              prod_valid;
  mm_pkg::word_t [SIMD_WIDTH-1:0]    prod_lanes;
  mm_pkg::word_t [SIMD_WIDTH-1:0]    row_sums;
  logic                              row_done;
  mm_pkg::word_t                     row_result;
  logic                              result_valid;

  // lane products, MULT_DEPTH+1 cycles
  mm_simd_multiplier #(.SIMD_WIDTH(SIMD_WIDTH)) u_mult (
    .CLK        (CLK),
    .RST        (RST),
    .vec_valid  (vec_valid),
    .a_lanes    (a_lanes),
    .b_lanes    (b_lanes),
    .prod_valid (prod_valid),
    .prod_lanes (prod_lanes)
  );

  mm_row_accumulator #(.SIMD_WIDTH(SIMD_WIDTH)) u_acc (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .matrix_size (matrix_size),
    .prod_valid  (prod_valid),
    .prod_lanes  (prod_lanes),
    .row_sums    (row_sums),
    .row_done    (row_done)
  );

  mm_adder_tree #(.SIMD_WIDTH(SIMD_WIDTH)) u_tree (
    .CLK          (CLK),
    .RST          (RST),
    .row_sums     (row_sums),
    .row_done     (row_done),
    .row_result   (row_result),
    .result_valid (result_valid)
  );

  mm_result_packer #(.SIMD_WIDTH(SIMD_WIDTH)) u_pack (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .row_result   (row_result),
    .result_valid (result_valid),
    .c_data       (c_data),
    .c_addr       (c_addr),
    .c_we         (c_we)
  );

endmodule

// File: tests/mm_dot_engine_tb.sv
module mm_dot_engine_tb;

  localparam int SIMD_WIDTH = 4;
  localparam int DRIVE_DLY  = 10;  // input skew after the rising edge
  // mult + sign reg, accumulator, tree levels, packer
  localparam int WE_LATENCY = mm_pkg::MULT_DEPTH + 1 + 1 + $clog2(SIMD_WIDTH) + 1;

  typedef enum int {SMALL_POS, MIXED_SIGN, EXTREME} op_mode_e;

  typedef struct {
    int       size;   // matrix_size in elements
    int       words;  // output words expected
    op_mode_e mode;
    bit       gaps;   // random idle cycles between strobes
  } stim_t;

  localparam int N_ENTRIES = 6;

  // size, words, operand mode, gaps
  stim_t stim_tab [N_ENTRIES] = '{
    '{8,  2, SMALL_POS,  1'b0},
    '{16, 1, MIXED_SIGN, 1'b0},
    '{4,  3, EXTREME,    1'b0},
    '{12, 2, MIXED_SIGN, 1'b1},
    '{8,  2, SMALL_POS,  1'b1},
    '{20, 1, EXTREME,    1'b0}
  };

  logic                           CLK;
  logic                           RST;
  logic                           start;
  mm_pkg::size_t                  matrix_size;
  logic                           vec_valid;
  mm_pkg::word_t [SIMD_WIDTH-1:0] a_lanes;
  mm_pkg::word_t [SIMD_WIDTH-1:0] b_lanes;
  mm_pkg::word_t [SIMD_WIDTH-1:0] c_data;
  mm_pkg::addr_t                  c_addr;
  logic                           c_we;

  int seed = 32'h58b7028d;

  mm_pkg::word_t [SIMD_WIDTH-1:0] exp_words [$];  // model output, filled by driver
  mm_pkg::addr_t                  exp_addrs [$];
  int                             rd_idx = 0;     // words seen on the write port
  int                             grp_end_cyc [$];
  int                             cyc = 0;
  int                             strobe_cnt = 0;
  int                             grp_ms = 1;
  bit                             seen_we = 1'b0;

  mm_dot_engine #(.SIMD_WIDTH(SIMD_WIDTH)) UUT (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .matrix_size (matrix_size),
    .vec_valid   (vec_valid),
    .a_lanes     (a_lanes),
    .b_lanes     (b_lanes),
    .c_data      (c_data),
    .c_addr      (c_addr),
    .c_we        (c_we)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  // --------------------------------------------------
  // reference model and operand source
  // --------------------------------------------------
  function automatic mm_pkg::word_t lane_product(input mm_pkg::word_t a, input mm_pkg::word_t b);
    longint p;
    p = longint'($signed(a)) * longint'($signed(b));
    return p[31:0];  // low word only, mod 2^32
  endfunction

  function automatic mm_pkg::word_t gen_operand(input op_mode_e mode);
    mm_pkg::word_t r;
    r = $random(seed);
    if (mode == SMALL_POS) begin
      return {24'd0, r[7:0]};
    end else if (mode == MIXED_SIGN) begin
      return r;
    end
    case (r[2:0])  // corners, most negative twice as often
      3'd0, 3'd1: return 32'h8000_0000;
      3'd2, 3'd3: return 32'h7fff_ffff;
      3'd4:       return 32'hffff_ffff;
      3'd5:       return 32'h0000_0001;
      3'd6:       return 32'h8000_0001;
      default:    return 32'h0000_0000;
    endcase
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_word(input mm_pkg::word_t [SIMD_WIDTH-1:0] got,
                            input mm_pkg::word_t [SIMD_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t: c_data %h, expected %h", $time, got, exp);
      $display("Finished with errors");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_addr(input mm_pkg::addr_t got, input mm_pkg::addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: c_addr %0d, expected %0d", $time, got, exp);
      $display("Finished with errors");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_latency(input int got);
    if (got != WE_LATENCY) begin
      $display("error at %0t: write came %0d cycles after last strobe, expected %0d",
               $time, got, WE_LATENCY);
      $display("Finished with errors");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic check_write();
    if (rd_idx >= exp_words.size()) begin
      $display("write pulse at %0t with no finished row group behind it", $time);
      $display("Finished with errors");
      $fatal(1, "unexpected write");
    end else begin
      check_word(c_data, exp_words[rd_idx]);
      check_addr(c_addr, exp_addrs[rd_idx]);
      check_latency(cyc - grp_end_cyc.pop_front());
      rd_idx  = rd_idx + 1;
      seen_we = 1'b1;
    end
  endtask

  // monitor, mid cycle where everything has settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (start) begin
        strobe_cnt = 0;
        grp_ms     = matrix_size;  // strobes per group of SIMD_WIDTH rows
      end
      if (vec_valid) begin
        strobe_cnt = strobe_cnt + 1;
        if (strobe_cnt % grp_ms == 0) grp_end_cyc.push_back(cyc);
      end
      if (c_we) check_write();
      else if (!seen_we) check_addr(c_addr, '0);  // idle after reset
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic run_entry(input stim_t st);
    int                             rows;
    int                             per_row;
    int                             gap;
    mm_pkg::word_t                  row_acc;
    mm_pkg::word_t [SIMD_WIDTH-1:0] a_v;
    mm_pkg::word_t [SIMD_WIDTH-1:0] b_v;
    mm_pkg::word_t [SIMD_WIDTH-1:0] packed_rows;
    rows        = st.words * SIMD_WIDTH;
    per_row     = st.size / SIMD_WIDTH;  // strobes per row
    start       = 1'b1;
    matrix_size = mm_pkg::size_t'(st.size);
    @(posedge CLK);
    #DRIVE_DLY;
    start = 1'b0;
    for (int r = 0; r < rows; r++) begin
      row_acc = '0;
      for (int w = 0; w < per_row; w++) begin
        for (int l = 0; l < SIMD_WIDTH; l++) begin
          a_v[l]  = gen_operand(st.mode);
          b_v[l]  = gen_operand(st.mode);
          row_acc = row_acc + lane_product(a_v[l], b_v[l]);
        end
        a_lanes   = a_v;
        b_lanes   = b_v;
        vec_valid = 1'b1;
        @(posedge CLK);
        #DRIVE_DLY;
        vec_valid = 1'b0;
        gap = st.gaps ? ($random(seed) & 3) : 0;
        repeat (gap) begin
          @(posedge CLK);
          #DRIVE_DLY;
        end
      end
      packed_rows[r % SIMD_WIDTH] = row_acc;  // lane 0 oldest
      if (r % SIMD_WIDTH == SIMD_WIDTH - 1) begin
        exp_words.push_back(packed_rows);
        exp_addrs.push_back(mm_pkg::addr_t'(r / SIMD_WIDTH));
      end
    end
    while (rd_idx < exp_words.size()) begin  // drain before next start
      @(posedge CLK);
      #DRIVE_DLY;
    end
    // stray word, leaves a partial row or a partly packed word for start to clear
    a_lanes   = {SIMD_WIDTH{32'd1}};
    b_lanes   = {SIMD_WIDTH{32'd1}};
    vec_valid = 1'b1;
    @(posedge CLK);
    #DRIVE_DLY;
    vec_valid = 1'b0;
    repeat (WE_LATENCY) begin  // pipeline empty before the next start
      @(posedge CLK);
      #DRIVE_DLY;
    end
  endtask

  initial begin : main
    int total_words;
    total_words = 0;
    RST         = 1'b1;
    start       = 1'b0;
    matrix_size = '0;
    vec_valid   = 1'b0;
    a_lanes     = '0;
    b_lanes     = '0;
    repeat (3) @(posedge CLK);
    #DRIVE_DLY;
    RST = 1'b0;
    repeat (4) begin  // idle, no writes expected
      @(posedge CLK);
      #DRIVE_DLY;
    end
    for (int e = 0; e < N_ENTRIES; e++) begin
      run_entry(stim_tab[e]);
      total_words = total_words + stim_tab[e].words;
    end
    repeat (4) @(posedge CLK);  // catch stray writes
    if (rd_idx == total_words) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("only %0d of %0d words were written", rd_idx, total_words);
      $display("Finished with errors");
      $fatal(1, "missing writes");
    end
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  function automatic int watchdog_cycles();
    int total;
    total = 20;  // reset and lead-in
    for (int e = 0; e < N_ENTRIES; e++) begin
      total = total + stim_tab[e].size * stim_tab[e].words * (stim_tab[e].gaps ? 4 : 1) + 20;
      total = total + 1 + WE_LATENCY;  // stray word and its drain
    end
    return total;
  endfunction

  initial begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge CLK);
    $display("simulation timed out after %0d cycles", limit);
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

endmodule

// File: sources.f
logic/mm_pkg.sv
logic/mm_simd_multiplier.sv
logic/mm_row_accumulator.sv
logic/mm_adder_tree.sv
logic/mm_result_packer.sv
logic/mm_dot_engine.sv
tests/mm_dot_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dot engine testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/mm_dot_engine_sim
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
  --top-module mm_dot_engine_tb \
  --Mdir obj_dir -o mm_dot_engine_sim \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$SIM" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
